// File: hdl/agen.sv
`timescale 1ns/1ps

module agen (
    input  rrag_pkg::opsize_t opsize,
    input  rrag_pkg::addr_t   base_reg,
    input  rrag_pkg::addr_t   index_reg,
    input  rrag_pkg::scale_t  scale,
    input  rrag_pkg::addr_t   disp,
    input  rrag_pkg::addr_t   seg_base,
    input  rrag_pkg::addr_t   seg_limit,
    output rrag_pkg::addr_t   lin_addr,
    output logic              fault
);
    import rrag_pkg::*;

    addr_t scaled_index;
    addr_t offset;
    addr_t span;
    addr_t end_offset;
    logic  end_carry;

    // Effective offset, wrapping modulo 2**32 like the real adder chain.
    always_comb begin
        scaled_index = index_reg << scale;
        offset       = base_reg + scaled_index + disp;
    end

    // Distance from the first to the last byte of the access.
    always_comb begin
        case (opsize)
            SZ_1: span = 32'd0;
            SZ_2: span = 32'd1;
            SZ_4: span = 32'd3;
            SZ_8: span = 32'd7;
            default: span = 32'd7;
        endcase
    end

    // The carry catches accesses that run past 4 GB even when the
    // truncated end offset would pass the limit test.
    assign {end_carry, end_offset} = {1'b0, offset} + {1'b0, span};

    assign fault = end_carry || (end_offset > seg_limit);

    assign lin_addr = seg_base + offset; // No paging, linear is physical.

endmodule

// File: hdl/mem_stage.sv
`timescale 1ns/1ps
`include "rrag_config.svh"

module mem_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               valid,
    input  rrag_pkg::opsize_t  opsize,
    input  rrag_pkg::mem_op_t  mem_op,
    input  rrag_pkg::addr_t    lin_addr,
    input  logic               fault,
    input  rrag_pkg::data_t    store_data,
    input  rrag_pkg::reg_id_t  dest,
    input  rrag_pkg::addr_t    eip,
    output logic               wb_valid,
    output rrag_pkg::data_t    wb_data,
    output rrag_pkg::reg_id_t  wb_dest,
    output rrag_pkg::addr_t    wb_eip,
    output logic               wb_fault
);
    import rrag_pkg::*;

    localparam int AW = `DMEM_AW;

    logic [7:0]    mem [`DMEM_DEPTH];
    logic [AW-1:0] base;
    logic [3:0]    nbytes;
    logic          wr_en;
    logic          rd_ok;
    data_t         rd_data;
    data_t         wb_data_d;
    logic          wb_fault_d;
    logic          wb_ld;

    // Byte i of an access, wrapping past the top of memory.
    function automatic logic [AW-1:0] byte_idx(input logic [AW-1:0] b, input int i);
        return b + i[AW-1:0];
    endfunction

    assign base   = lin_addr[AW-1:0];
    assign nbytes = 4'd1 << opsize;
    assign wb_ld  = !stall;

    assign wr_en = wb_ld && valid && (mem_op == MEM_WR) && !fault;
    assign rd_ok = valid && (mem_op == MEM_RD) && !fault;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                mem[i] <= 8'h00;
            end
        end else if (wr_en) begin
            for (int i = 0; i < 8; i++) begin
                if (i < nbytes) begin
                    mem[byte_idx(base, i)] <= store_data[8*i +: 8];
                end
            end
        end
    end

    // Little-endian gather, upper bytes stay zero.
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < nbytes) begin
                rd_data[8*i +: 8] = mem[byte_idx(base, i)];
            end
        end
    end

    assign wb_data_d  = rd_ok ? rd_data : '0;
    assign wb_fault_d = valid && fault;

    pipe_reg #(.T(logic)) u_wb_valid (
        .clk(clk), .rst_n(rst_n), .ld(wb_ld), .clr(1'b0), .din(valid), .dout(wb_valid)
    );

    pipe_reg #(.T(data_t)) u_wb_data (
        .clk(clk), .rst_n(rst_n), .ld(wb_ld), .clr(1'b0), .din(wb_data_d), .dout(wb_data)
    );

    pipe_reg #(.T(reg_id_t)) u_wb_dest (
        .clk(clk), .rst_n(rst_n), .ld(wb_ld), .clr(1'b0), .din(dest), .dout(wb_dest)
    );

    pipe_reg #(.T(addr_t)) u_wb_eip (
        .clk(clk), .rst_n(rst_n), .ld(wb_ld), .clr(1'b0), .din(eip), .dout(wb_eip)
    );

    pipe_reg #(.T(logic)) u_wb_fault (
        .clk(clk), .rst_n(rst_n), .ld(wb_ld), .clr(1'b0), .din(wb_fault_d), .dout(wb_fault)
    );

    // A faulted or invalid item leaves the first byte it addresses unchanged.
    a_no_bad_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!valid || fault) |=> (mem[$past(base)] == $past(mem[base]))
    ) else $error("mem_stage: write committed for a faulted or invalid item");

endmodule

// File: hdl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic ld,
    input  logic clr,
    input  T     din,
    output T     dout
);

    // Clear wins over load, so a flush drops whatever is arriving.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout <= T'(0);
        end else if (clr) begin
            dout <= T'(0);
        end else if (ld) begin
            dout <= din;
        end
    end

    a_din_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ld && !clr) |-> !$isunknown(din)
    ) else $error("pipe_reg: loading unknown bits");

endmodule

// File: hdl/rrag_config.svh
`ifndef RRAG_CONFIG_SVH
`define RRAG_CONFIG_SVH

// Data memory size in bytes. DMEM_DEPTH must equal 2**DMEM_AW so that
// byte indices wrap by simple truncation.
`define DMEM_DEPTH 256

`define DMEM_AW 8 // Width of a byte index.

`endif

// File: hdl/rrag_mem_latch.sv
`timescale 1ns/1ps

module rrag_mem_latch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               valid_in,
    input  rrag_pkg::opsize_t  opsize_in,
    input  rrag_pkg::mem_op_t  mem_op_in,
    input  rrag_pkg::addr_t    lin_addr_in,
    input  logic               fault_in,
    input  rrag_pkg::data_t    store_data_in,
    input  rrag_pkg::reg_id_t  dest_in,
    input  rrag_pkg::addr_t    eip_in,
    output logic               valid_out,
    output rrag_pkg::opsize_t  opsize_out,
    output rrag_pkg::mem_op_t  mem_op_out,
    output rrag_pkg::addr_t    lin_addr_out,
    output logic               fault_out,
    output rrag_pkg::data_t    store_data_out,
    output rrag_pkg::reg_id_t  dest_out,
    output rrag_pkg::addr_t    eip_out
);
    import rrag_pkg::*;

    logic ld;
    logic clr;

    // Every field shares one load and one clear.
    assign ld  = !stall;
    assign clr = flush;

    pipe_reg #(.T(logic)) u_valid (
        .clk(clk), .rst_n(rst_n), .ld(ld), .clr(clr), .din(valid_in), .dout(valid_out)
    );

    pipe_reg #(.T(opsize_t)) u_opsize (
        .clk(clk), .rst_n(rst_n), .ld(ld), .clr(clr), .din(opsize_in), .dout(opsize_out)
    );

    pipe_reg #(.T(mem_op_t)) u_mem_op (
        .clk(clk), .rst_n(rst_n), .ld(ld), .clr(clr), .din(mem_op_in), .dout(mem_op_out)
    );

    pipe_reg #(.T(addr_t)) u_lin_addr (
        .clk(clk), .rst_n(rst_n), .ld(ld), .clr(clr),
        .din(lin_addr_in), .dout(lin_addr_out)
    );

    pipe_reg #(.T(logic)) u_fault (
        .clk(clk), .rst_n(rst_n), .ld(ld), .clr(clr), .din(fault_in), .dout(fault_out)
    );

    pipe_reg #(.T(data_t)) u_store_data (
        .clk(clk), .rst_n(rst_n), .ld(ld), .clr(clr),
        .din(store_data_in), .dout(store_data_out)
    );

    pipe_reg #(.T(reg_id_t)) u_dest (
        .clk(clk), .rst_n(rst_n), .ld(ld), .clr(clr), .din(dest_in), .dout(dest_out)
    );

    pipe_reg #(.T(addr_t)) u_eip (
        .clk(clk), .rst_n(rst_n), .ld(ld), .clr(clr), .din(eip_in), .dout(eip_out)
    );

    // A flush must kill the latch even while the pipe is stalled.
    a_flush_kills: assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> !valid_out
    ) else $error("rrag_mem_latch: valid survived a flush");

endmodule

// File: hdl/rrag_mem_top.sv
`timescale 1ns/1ps

module rrag_mem_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               stall,
    input  logic               flush,
    input  logic               in_valid,
    input  rrag_pkg::opsize_t  opsize,
    input  rrag_pkg::mem_op_t  mem_op,
    input  rrag_pkg::addr_t    seg_base,
    input  rrag_pkg::addr_t    seg_limit,
    input  rrag_pkg::addr_t    base_reg,
    input  rrag_pkg::addr_t    index_reg,
    input  rrag_pkg::scale_t   scale,
    input  rrag_pkg::addr_t    disp,
    input  rrag_pkg::data_t    store_data,
    input  rrag_pkg::reg_id_t  dest,
    input  rrag_pkg::addr_t    eip,
    output logic               wb_valid,
    output rrag_pkg::data_t    wb_data,
    output rrag_pkg::reg_id_t  wb_dest,
    output rrag_pkg::addr_t    wb_eip,
    output logic               wb_fault
);
    import rrag_pkg::*;

    addr_t   ag_lin_addr;
    logic    ag_fault;

    logic    m_valid;
    opsize_t m_opsize;
    mem_op_t m_mem_op;
    addr_t   m_lin_addr;
    logic    m_fault;
    data_t   m_store_data;
    reg_id_t m_dest;
    addr_t   m_eip;

    agen u_agen (
        .opsize    (opsize),
        .base_reg  (base_reg),
        .index_reg (index_reg),
        .scale     (scale),
        .disp      (disp),
        .seg_base  (seg_base),
        .seg_limit (seg_limit),
        .lin_addr  (ag_lin_addr),
        .fault     (ag_fault)
    );

    rrag_mem_latch u_latch (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .flush          (flush),
        .valid_in       (in_valid),
        .opsize_in      (opsize),
        .mem_op_in      (mem_op),
        .lin_addr_in    (ag_lin_addr),
        .fault_in       (ag_fault),
        .store_data_in  (store_data),
        .dest_in        (dest),
        .eip_in         (eip),
        .valid_out      (m_valid),
        .opsize_out     (m_opsize),
        .mem_op_out     (m_mem_op),
        .lin_addr_out   (m_lin_addr),
        .fault_out      (m_fault),
        .store_data_out (m_store_data),
        .dest_out       (m_dest),
        .eip_out        (m_eip)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .valid      (m_valid),
        .opsize     (m_opsize),
        .mem_op     (m_mem_op),
        .lin_addr   (m_lin_addr),
        .fault      (m_fault),
        .store_data (m_store_data),
        .dest       (m_dest),
        .eip        (m_eip),
        .wb_valid   (wb_valid),
        .wb_data    (wb_data),
        .wb_dest    (wb_dest),
        .wb_eip     (wb_eip),
        .wb_fault   (wb_fault)
    );

endmodule

// File: hdl/rrag_pkg.sv
package rrag_pkg;

    // Offsets, linear addresses, segment base/limit and EIP.
    typedef logic [31:0] addr_t;

    typedef logic [63:0] data_t; // Store data and load result.

    typedef logic [2:0] reg_id_t;

    // A size code n means 2**n bytes.
    typedef enum logic [1:0] {
        SZ_1 = 2'd0,
        SZ_2 = 2'd1,
        SZ_4 = 2'd2,
        SZ_8 = 2'd3
    } opsize_t;

    typedef enum logic [1:0] {
        MEM_NONE = 2'd0,
        MEM_RD   = 2'd1,
        MEM_WR   = 2'd2
    } mem_op_t;

    typedef logic [1:0] scale_t; // Index shift amount.

endpackage

// File: list.f
+incdir+hdl
hdl/rrag_pkg.sv
hdl/pipe_reg.sv
hdl/agen.sv
hdl/rrag_mem_latch.sv
hdl/mem_stage.sv
hdl/rrag_mem_top.sv
verif/tb_rrag_mem.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and judge the run from the simulation log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_rrag_mem -f list.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_rrag_mem > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
grep -q "=== PASS ===" sim.log || exit 1
exit 0

// File: verif/rrag_mem_golden.txt
// kill opsize mem_op seg_base seg_limit base index scale disp store_data dest eip
// then expected wb_data and wb_fault; every field is hex
0 0 1 00001000 0000ffff 00000010 00000000 0 00000000 0000000000000000 1 00400000 0000000000000000 0
0 1 1 00001000 0000ffff 00000020 00000000 0 00000000 0000000000000000 2 00400004 0000000000000000 0
0 2 1 00001000 0000ffff 00000030 00000000 0 00000000 0000000000000000 3 00400008 0000000000000000 0
0 3 1 00001000 0000ffff 00000040 00000000 0 00000000 0000000000000000 4 0040000c 0000000000000000 0
0 3 2 00001000 0000ffff 00000040 00000004 2 00000000 8877665544332211 5 00400010 0000000000000000 0
0 2 1 00001000 0000ffff 00000050 00000001 1 00000000 0000000000000000 6 00400014 0000000066554433 0
0 1 2 00001000 0000ffff 00000060 00000000 0 fffffff6 ffffffffffffabcd 7 00400018 0000000000000000 0
0 3 1 00001000 0000ffff 00000000 00000028 1 00000000 0000000000000000 0 0040001c abcd665544332211 0
0 0 2 00001000 0000ffff 00000000 00000051 0 00000000 00000000000000ee 1 00400020 0000000000000000 0
0 1 1 00001000 0000ffff 00000050 00000000 0 00000000 0000000000000000 2 00400024 000000000000ee11 0
0 0 1 00001000 0000ffff 00000050 00000007 0 00000000 0000000000000000 3 00400028 00000000000000ab 0
0 2 2 00001000 0000ffff 000000f0 00000007 1 00000000 00000000deadbeef 4 0040002c 0000000000000000 0
0 3 1 000010f0 0000ffff 00000004 00000001 3 00000000 0000000000000000 5 00400030 0000deadbeef0000 0
0 1 1 00000100 0000ffff 000000ff 00000000 0 00000000 0000000000000000 6 00400034 000000000000adbe 0
0 2 2 00001000 00000103 00000101 00000000 0 00000000 0000000011111111 7 00400038 0000000000000000 1
0 2 1 00001000 0000ffff 00000100 00000001 0 00000000 0000000000000000 0 0040003c 00000000000000de 0
0 3 1 00000000 ffffffff fffffffc 00000000 0 00000000 0000000000000000 1 00400040 0000000000000000 1
0 1 1 00001000 0000004f 0000004f 00000000 0 00000000 0000000000000000 2 00400044 0000000000000000 1
1 3 2 00001000 0000ffff 00000080 00000000 0 00000000 0123456789abcdef 3 00400048 0000000000000000 0
0 3 1 00001000 0000ffff 00000080 00000000 0 00000000 0000000000000000 4 0040004c 0000000000000000 0
1 2 1 00001000 0000ffff 00000050 00000000 0 00000000 0000000000000000 5 00400050 0000000000000000 0
0 0 0 00001000 0000ffff 00000010 00000000 0 00000000 ffffffffffffffff 6 00400054 0000000000000000 0
0 2 2 00001000 0000ffff 00000100 00000000 0 ffffff80 00000000cafef00d 7 00400058 0000000000000000 0
0 3 1 00001000 0000ffff 0000007e 00000000 0 00000000 0000000000000000 0 0040005c 0000cafef00d0000 0

// File: verif/tb_rrag_mem.sv
`timescale 1ns/1ps

module tb_rrag_mem;
    import rrag_pkg::*;

    localparam string GOLDEN_FILE = "verif/rrag_mem_golden.txt";

    typedef struct packed {
        logic    kill;
        opsize_t opsize;
        mem_op_t mem_op;
        addr_t   seg_base;
        addr_t   seg_limit;
        addr_t   base_reg;
        addr_t   index_reg;
        scale_t  scale;
        addr_t   disp;
        data_t   store_data;
        reg_id_t dest;
        addr_t   eip;
        data_t   exp_data;
        logic    exp_fault;
    } vec_t;

    typedef struct packed {
        reg_id_t dest;
        addr_t   eip;
        data_t   data;
        logic    fault;
    } exp_t;

    logic    clk;
    logic    rst_n;
    logic    stall;
    logic    flush;
    logic    in_valid;
    opsize_t opsize;
    mem_op_t mem_op;
    addr_t   seg_base;
    addr_t   seg_limit;
    addr_t   base_reg;
    addr_t   index_reg;
    scale_t  scale;
    addr_t   disp;
    data_t   store_data;
    reg_id_t dest;
    addr_t   eip;
    logic    wb_valid;
    data_t   wb_data;
    reg_id_t wb_dest;
    addr_t   wb_eip;
    logic    wb_fault;

    vec_t vecs[$];
    exp_t exp_q[$];
    exp_t head;
    logic fresh;        // The wb registers loaded at the last rising edge.
    int   cycles;
    int   cycle_limit;
    int   err_data;
    int   err_reg;
    int   err_addr;
    int   err_bit;
    int   err_other;

    rrag_mem_top uut (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush), .in_valid(in_valid),
        .opsize(opsize), .mem_op(mem_op), .seg_base(seg_base), .seg_limit(seg_limit),
        .base_reg(base_reg), .index_reg(index_reg), .scale(scale), .disp(disp),
        .store_data(store_data), .dest(dest), .eip(eip), .wb_valid(wb_valid),
        .wb_data(wb_data), .wb_dest(wb_dest), .wb_eip(wb_eip), .wb_fault(wb_fault)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        fresh  <= rst_n && !stall;
    end

    task automatic check_data(input data_t exp, input data_t act, input string what);
        if (act !== exp) begin
            err_data++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, what, exp, act);
        end
    endtask

    task automatic check_reg(input reg_id_t exp, input reg_id_t act, input string what);
        if (act !== exp) begin
            err_reg++;
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, what, exp, act);
        end
    endtask

    task automatic check_addr(input addr_t exp, input addr_t act, input string what);
        if (act !== exp) begin
            err_addr++;
            $display("mismatch at %0t: %s expected %h, got %h", $time, what, exp, act);
        end
    endtask

    task automatic check_bit(input logic exp, input logic act, input string what);
        if (act !== exp) begin
            err_bit++;
            $display("mismatch at %0t: %s expected %b, got %b", $time, what, exp, act);
        end
    endtask

    function automatic int total_errors();
        return err_data + err_reg + err_addr + err_bit + err_other;
    endfunction

    task automatic report_counts();
        $display("errors: data %0d, reg %0d, addr %0d, bit %0d, other %0d",
                 err_data, err_reg, err_addr, err_bit, err_other);
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        vec_t        v;
        logic [63:0] t_kill, t_sz, t_op, t_sb, t_sl, t_base, t_idx;
        logic [63:0] t_sc, t_disp, t_st, t_dest, t_eip, t_exp, t_flt;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            err_other++;
            $display("cannot open golden file %s", GOLDEN_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                t_kill, t_sz, t_op, t_sb, t_sl, t_base, t_idx,
                                t_sc, t_disp, t_st, t_dest, t_eip, t_exp, t_flt);
                    if (n != 14) begin
                        err_other++;
                        $display("malformed golden line: %s", line);
                    end else begin
                        v.kill       = t_kill[0];
                        v.opsize     = opsize_t'(t_sz[1:0]);
                        v.mem_op     = mem_op_t'(t_op[1:0]);
                        v.seg_base   = t_sb[31:0];
                        v.seg_limit  = t_sl[31:0];
                        v.base_reg   = t_base[31:0];
                        v.index_reg  = t_idx[31:0];
                        v.scale      = t_sc[1:0];
                        v.disp       = t_disp[31:0];
                        v.store_data = t_st;
                        v.dest       = t_dest[2:0];
                        v.eip        = t_eip[31:0];
                        v.exp_data   = t_exp;
                        v.exp_fault  = t_flt[0];
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_item(input vec_t v);
        in_valid   = 1'b1;
        opsize     = v.opsize;
        mem_op     = v.mem_op;
        seg_base   = v.seg_base;
        seg_limit  = v.seg_limit;
        base_reg   = v.base_reg;
        index_reg  = v.index_reg;
        scale      = v.scale;
        disp       = v.disp;
        store_data = v.store_data;
        dest       = v.dest;
        eip        = v.eip;
    endtask

    task automatic drive_idle();
        stall    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        opsize   = SZ_1;
        mem_op   = MEM_NONE;
        seg_base = '0;
        seg_limit = '0;
        base_reg = '0;
        index_reg = '0;
        scale    = '0;
        disp     = '0;
        store_data = '0;
        dest     = '0;
        eip      = '0;
    endtask

    // Each fresh wb_valid retires the oldest expected item.
    always @(negedge clk) begin
        if (fresh && wb_valid) begin
            if (exp_q.size() == 0) begin
                err_other++;
                $display("wb_valid at %0t with no result expected", $time);
            end else begin
                head = exp_q.pop_front();
                check_reg(head.dest, wb_dest, "wb_dest");
                check_addr(head.eip, wb_eip, "wb_eip");
                check_data(head.data, wb_data, "wb_data");
                check_bit(head.fault, wb_fault, "wb_fault");
            end
        end
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
        report_counts();
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic accepted;
        exp_t e;
        void'($urandom(32'hf953_f8ae));
        clk = 1'b0;
        rst_n = 1'b0;
        fresh = 1'b0;
        cycles = 0;
        cycle_limit = 0;
        err_data = 0;
        err_reg = 0;
        err_addr = 0;
        err_bit = 0;
        err_other = 0;
        drive_idle();
        load_golden();
        if (vecs.size() == 0) begin
            err_other++;
            $display("golden file holds no vectors");
        end
        cycle_limit = 20 * vecs.size() + 100;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit(1'b0, wb_valid, "wb_valid after reset");
        check_bit(1'b0, wb_fault, "wb_fault after reset");
        foreach (vecs[i]) begin
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                drive_item(vecs[i]);
                if (vecs[i].kill) begin   // Flush drops the item as it enters the latch.
                    stall = 1'b0;
                    flush = 1'b1;
                end else begin
                    stall = ($urandom % 4) == 0;
                    flush = 1'b0;
                end
                accepted = !stall;
            end
            if (!vecs[i].kill) begin
                e.dest  = vecs[i].dest;
                e.eip   = vecs[i].eip;
                e.data  = vecs[i].exp_data;
                e.fault = vecs[i].exp_fault;
                exp_q.push_back(e);
            end
        end
        @(negedge clk);
        drive_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk); // Any stray result shows up here.
        if (exp_q.size() != 0) begin
            err_other++;
            $display("%0d expected results never appeared", exp_q.size());
        end
        report_counts();
        if (total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
